// ==== hw/axi4_mon_pkg.sv ====
/*
 * AXI4 monitor package: bus field widths, channel record structs,
 * tracker error kinds and the statistics record.
 */

package axi4_mon_pkg;

	// bus geometry.
	localparam int ADDR_WIDTH = 32;
	localparam int ID_WIDTH   = 4;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	localparam int LEN_WIDTH  = 8;

	// width of each counter field in the statistics record.
	// the stats block saturates at its own CNT_WIDTH and zero-extends.
	localparam int STAT_WIDTH = 16;

	typedef logic [STAT_WIDTH-1:0] stat_cnt_t;

	// address phase, same layout for AR and AW.
	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
		logic [2:0]            size;
		logic [1:0]            burst;
		logic                  lock;
		logic [3:0]            cache;
		logic [2:0]            prot;
		logic [3:0]            qos;
		logic [3:0]            region;
	} addr_chan_t;

	// read data beat.
	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;
		logic                  last;
	} rbeat_t;

	// write data beat, no id in AXI4.
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic                  last;
	} wbeat_t;

	// write response.
	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		logic [1:0]          resp;
	} bresp_t;

	// burst tracker error kinds; overflow has its own strobe.
	typedef enum logic [1:0] {
		ERR_NONE         = 2'd0,
		ERR_EARLY_LAST   = 2'd1,
		ERR_MISSING_LAST = 2'd2,
		ERR_ORPHAN_BEAT  = 2'd3
	} mon_err_e;

	// everything the monitor exposes at the top.
	typedef struct packed {
		stat_cnt_t ar;
		stat_cnt_t aw;
		stat_cnt_t r_beats;
		stat_cnt_t w_beats;
		stat_cnt_t b_resp;
		stat_cnt_t rd_bursts;
		stat_cnt_t wr_bursts;
		stat_cnt_t resp_err;
		stat_cnt_t last_err;
		stat_cnt_t orphan_err;
		stat_cnt_t overflow_err;
		logic      any_err;
	} mon_stats_t;

endpackage

// ==== hw/axi4_handshake_decode.sv ====
/*
 * Handshake decode: one registered record and strobe per AXI4 channel,
 * plus per-channel error response flags for R and B.
 */

`timescale 1ns/1ps

module axi4_handshake_decode (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ar_valid,
	input  logic                     ar_ready,
	input  axi4_mon_pkg::addr_chan_t ar,
	input  logic                     aw_valid,
	input  logic                     aw_ready,
	input  axi4_mon_pkg::addr_chan_t aw,
	input  logic                     r_valid,
	input  logic                     r_ready,
	input  axi4_mon_pkg::rbeat_t     r,
	input  logic                     w_valid,
	input  logic                     w_ready,
	input  axi4_mon_pkg::wbeat_t     w,
	input  logic                     b_valid,
	input  logic                     b_ready,
	input  axi4_mon_pkg::bresp_t     b,
	output logic                     ar_evt,
	output axi4_mon_pkg::addr_chan_t ar_rec,
	output logic                     aw_evt,
	output axi4_mon_pkg::addr_chan_t aw_rec,
	output logic                     r_evt,
	output axi4_mon_pkg::rbeat_t     r_rec,
	output logic                     w_evt,
	output axi4_mon_pkg::wbeat_t     w_rec,
	output logic                     b_evt,
	output axi4_mon_pkg::bresp_t     b_rec,
	output logic [1:0]               resp_err_evt
);

	import axi4_mon_pkg::*;

	logic ar_hs;
	logic aw_hs;
	logic r_hs;
	logic w_hs;
	logic b_hs;

	// a transfer happens when both sides agree at the edge.
	assign ar_hs = ar_valid && ar_ready;
	assign aw_hs = aw_valid && aw_ready;
	assign r_hs  = r_valid && r_ready;
	assign w_hs  = w_valid && w_ready;
	assign b_hs  = b_valid && b_ready;

	// strobes, one cycle per handshake.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ar_evt       <= 1'b0;
			aw_evt       <= 1'b0;
			r_evt        <= 1'b0;
			w_evt        <= 1'b0;
			b_evt        <= 1'b0;
			resp_err_evt <= 2'b00;
		end else begin
			ar_evt          <= ar_hs;
			aw_evt          <= aw_hs;
			r_evt           <= r_hs;
			w_evt           <= w_hs;
			b_evt           <= b_hs;
			// bit 0 read side, bit 1 write side; both may fire together.
			resp_err_evt[0] <= r_hs && (r.resp != 2'b00);
			resp_err_evt[1] <= b_hs && (b.resp != 2'b00);
		end
	end

	// payload held until the next handshake on the same channel.
	always_ff @(posedge clk) begin
		if (ar_hs) ar_rec <= ar;
		if (aw_hs) aw_rec <= aw;
		if (r_hs) r_rec <= r;
		if (w_hs) w_rec <= w;
		if (b_hs) b_rec <= b;
	end

endmodule

// ==== hw/axi4_burst_tracker.sv ====
/*
 * Burst tracker: queues burst lengths from the address channel and
 * checks data beats and LAST against the burst at the head.
 * Flags early/missing LAST, orphan beats and queue overflow.
 */

`timescale 1ns/1ps

module axi4_burst_tracker #(
	parameter int  BURST_DEPTH = 4,
	parameter type beat_t      = axi4_mon_pkg::rbeat_t
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               addr_evt,
	input  logic [axi4_mon_pkg::LEN_WIDTH-1:0] addr_len,
	input  logic                               beat_evt,
	input  logic                               beat_last,
	input  beat_t                              beat,
	output logic                               burst_done,
	output logic                               err_valid,
	output axi4_mon_pkg::mon_err_e             err_kind,
	output logic                               err_overflow
);

	import axi4_mon_pkg::*;

	localparam int PTR_WIDTH  = (BURST_DEPTH > 1) ? $clog2(BURST_DEPTH) : 1;
	localparam int FILL_WIDTH = $clog2(BURST_DEPTH + 1);

	logic [LEN_WIDTH-1:0]  len_q [BURST_DEPTH];
	logic [PTR_WIDTH-1:0]  rd_ptr;
	logic [PTR_WIDTH-1:0]  wr_ptr;
	logic [FILL_WIDTH-1:0] fill;
	logic [LEN_WIDTH-1:0]  beat_cnt;
	beat_t                 head_beat_q;
	logic                  empty;
	logic                  full;
	logic                  final_beat;
	logic                  push;
	logic                  pop;

	// wrap for depths that are not a power of two.
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(BURST_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_WIDTH'(1);
	endfunction

	assign empty      = (fill == '0);
	assign full       = (fill == FILL_WIDTH'(BURST_DEPTH));
	assign final_beat = (beat_cnt == len_q[rd_ptr]);

	// beat checked against the current head before any new address lands.
	always_comb begin
		pop        = 1'b0;
		burst_done = 1'b0;
		err_valid  = 1'b0;
		err_kind   = ERR_NONE;
		if (beat_evt) begin
			if (empty) begin
				err_valid = 1'b1;
				err_kind  = ERR_ORPHAN_BEAT;
			end else if (final_beat) begin
				pop = 1'b1;
				if (beat_last) begin
					burst_done = 1'b1;
				end else begin
					err_valid = 1'b1;
					err_kind  = ERR_MISSING_LAST;
				end
			end else if (beat_last) begin
				// burst closed short, drop the rest of it.
				pop       = 1'b1;
				err_valid = 1'b1;
				err_kind  = ERR_EARLY_LAST;
			end
		end
	end

	// a slot freed by this cycle's pop can take the new address.
	assign push         = addr_evt && (!full || pop);
	assign err_overflow = addr_evt && full && !pop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			fill     <= '0;
			beat_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr   <= next_ptr(rd_ptr);
				beat_cnt <= '0;
			end else if (beat_evt && !empty) begin
				beat_cnt <= beat_cnt + LEN_WIDTH'(1);
			end
			case ({push, pop})
				2'b10: fill <= fill + FILL_WIDTH'(1);
				2'b01: fill <= fill - FILL_WIDTH'(1);
				default: fill <= fill;
			endcase
		end
	end

	// length storage.
	always_ff @(posedge clk) begin
		if (push) begin
			len_q[wr_ptr] <= addr_len;
		end
	end

	// first beat of the head burst, kept for debug.
	always_ff @(posedge clk) begin
		if (beat_evt && !empty && (beat_cnt == '0)) begin
			head_beat_q <= beat;
		end
	end

endmodule

// ==== hw/axi4_mon_stats.sv ====
/*
 * Monitor statistics: saturating event, burst and error counters,
 * sticky any_err and a pulse on each new protocol error.
 */

`timescale 1ns/1ps

module axi4_mon_stats #(
	parameter int CNT_WIDTH = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         ar_evt,
	input  logic                         aw_evt,
	input  logic                         r_evt,
	input  logic                         w_evt,
	input  logic                         b_evt,
	input  logic [1:0]                   resp_err_evt,
	input  logic                         rd_burst_done,
	input  logic                         rd_err_valid,
	input  axi4_mon_pkg::mon_err_e       rd_err_kind,
	input  logic                         rd_err_overflow,
	input  logic                         wr_burst_done,
	input  logic                         wr_err_valid,
	input  axi4_mon_pkg::mon_err_e       wr_err_kind,
	input  logic                         wr_err_overflow,
	output axi4_mon_pkg::mon_stats_t     stats,
	output logic                         err_pulse
);

	import axi4_mon_pkg::*;

	logic [CNT_WIDTH-1:0] cnt_q [11];
	logic [1:0]           inc [11];
	logic                 rd_last_err;
	logic                 wr_last_err;
	logic                 rd_orphan;
	logic                 wr_orphan;
	logic                 any_err_q;
	logic                 new_err;

	// increments of 0..2, clamped at all ones.
	function automatic logic [CNT_WIDTH-1:0] sat_add(input logic [CNT_WIDTH-1:0] cnt,
			input logic [1:0] step);
		logic [CNT_WIDTH:0] sum;
		sum = {1'b0, cnt} + {{(CNT_WIDTH - 1){1'b0}}, step};
		if (sum[CNT_WIDTH]) begin
			return '1;
		end
		return sum[CNT_WIDTH-1:0];
	endfunction

	assign rd_last_err = rd_err_valid && (rd_err_kind inside {ERR_EARLY_LAST, ERR_MISSING_LAST});
	assign wr_last_err = wr_err_valid && (wr_err_kind inside {ERR_EARLY_LAST, ERR_MISSING_LAST});
	assign rd_orphan   = rd_err_valid && (rd_err_kind == ERR_ORPHAN_BEAT);
	assign wr_orphan   = wr_err_valid && (wr_err_kind == ERR_ORPHAN_BEAT);
	assign new_err     = rd_err_valid || wr_err_valid || rd_err_overflow || wr_err_overflow;

	// counter order matches the stats record.
	assign inc[0]  = {1'b0, ar_evt};
	assign inc[1]  = {1'b0, aw_evt};
	assign inc[2]  = {1'b0, r_evt};
	assign inc[3]  = {1'b0, w_evt};
	assign inc[4]  = {1'b0, b_evt};
	assign inc[5]  = {1'b0, rd_burst_done};
	assign inc[6]  = {1'b0, wr_burst_done};
	assign inc[7]  = {1'b0, resp_err_evt[0]} + {1'b0, resp_err_evt[1]};
	assign inc[8]  = {1'b0, rd_last_err} + {1'b0, wr_last_err};
	assign inc[9]  = {1'b0, rd_orphan} + {1'b0, wr_orphan};
	assign inc[10] = {1'b0, rd_err_overflow} + {1'b0, wr_err_overflow};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 11; i++) begin
				cnt_q[i] <= '0;
			end
			any_err_q <= 1'b0;
			err_pulse <= 1'b0;
		end else begin
			for (int i = 0; i < 11; i++) begin
				cnt_q[i] <= sat_add(cnt_q[i], inc[i]);
			end
			// sticky until reset.
			if (new_err || (resp_err_evt != 2'b00)) begin
				any_err_q <= 1'b1;
			end
			err_pulse <= new_err;
		end
	end

	assign stats.ar           = stat_cnt_t'(cnt_q[0]);
	assign stats.aw           = stat_cnt_t'(cnt_q[1]);
	assign stats.r_beats      = stat_cnt_t'(cnt_q[2]);
	assign stats.w_beats      = stat_cnt_t'(cnt_q[3]);
	assign stats.b_resp       = stat_cnt_t'(cnt_q[4]);
	assign stats.rd_bursts    = stat_cnt_t'(cnt_q[5]);
	assign stats.wr_bursts    = stat_cnt_t'(cnt_q[6]);
	assign stats.resp_err     = stat_cnt_t'(cnt_q[7]);
	assign stats.last_err     = stat_cnt_t'(cnt_q[8]);
	assign stats.orphan_err   = stat_cnt_t'(cnt_q[9]);
	assign stats.overflow_err = stat_cnt_t'(cnt_q[10]);
	assign stats.any_err      = any_err_q;

endmodule

// ==== hw/axi4_bus_monitor.sv ====
/*
 * Passive AXI4 bus monitor top: handshake decode, read and write
 * burst trackers and the statistics block.
 */

`timescale 1ns/1ps

module axi4_bus_monitor #(
	parameter int CNT_WIDTH   = 16,
	parameter int BURST_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     ar_valid,
	input  logic                     ar_ready,
	input  axi4_mon_pkg::addr_chan_t ar,
	input  logic                     aw_valid,
	input  logic                     aw_ready,
	input  axi4_mon_pkg::addr_chan_t aw,
	input  logic                     r_valid,
	input  logic                     r_ready,
	input  axi4_mon_pkg::rbeat_t     r,
	input  logic                     w_valid,
	input  logic                     w_ready,
	input  axi4_mon_pkg::wbeat_t     w,
	input  logic                     b_valid,
	input  logic                     b_ready,
	input  axi4_mon_pkg::bresp_t     b,
	output axi4_mon_pkg::mon_stats_t stats,
	output logic                     err_pulse
);

	import axi4_mon_pkg::*;

	logic       ar_evt;
	logic       aw_evt;
	logic       r_evt;
	logic       w_evt;
	logic       b_evt;
	addr_chan_t ar_rec;
	addr_chan_t aw_rec;
	rbeat_t     r_rec;
	wbeat_t     w_rec;
	bresp_t     b_rec;
	logic [1:0] resp_err_evt;
	logic       rd_burst_done;
	logic       rd_err_valid;
	mon_err_e   rd_err_kind;
	logic       rd_err_overflow;
	logic       wr_burst_done;
	logic       wr_err_valid;
	mon_err_e   wr_err_kind;
	logic       wr_err_overflow;

	axi4_handshake_decode decode_inst (
		.clk, .rst_n,
		.ar_valid, .ar_ready, .ar,
		.aw_valid, .aw_ready, .aw,
		.r_valid, .r_ready, .r,
		.w_valid, .w_ready, .w,
		.b_valid, .b_ready, .b,
		.ar_evt, .ar_rec, .aw_evt, .aw_rec,
		.r_evt, .r_rec, .w_evt, .w_rec,
		.b_evt, .b_rec, .resp_err_evt
	);

	// read side, AR lengths against R beats.
	axi4_burst_tracker #(.BURST_DEPTH(BURST_DEPTH), .beat_t(rbeat_t)) rd_tracker (
		.clk, .rst_n,
		.addr_evt(ar_evt), .addr_len(ar_rec.len),
		.beat_evt(r_evt), .beat_last(r_rec.last), .beat(r_rec),
		.burst_done(rd_burst_done), .err_valid(rd_err_valid),
		.err_kind(rd_err_kind), .err_overflow(rd_err_overflow)
	);

	// write side, AW lengths against W beats.
	axi4_burst_tracker #(.BURST_DEPTH(BURST_DEPTH), .beat_t(wbeat_t)) wr_tracker (
		.clk, .rst_n,
		.addr_evt(aw_evt), .addr_len(aw_rec.len),
		.beat_evt(w_evt), .beat_last(w_rec.last), .beat(w_rec),
		.burst_done(wr_burst_done), .err_valid(wr_err_valid),
		.err_kind(wr_err_kind), .err_overflow(wr_err_overflow)
	);

	axi4_mon_stats #(.CNT_WIDTH(CNT_WIDTH)) stats_inst (
		.clk, .rst_n,
		.ar_evt, .aw_evt, .r_evt, .w_evt, .b_evt, .resp_err_evt,
		.rd_burst_done, .rd_err_valid, .rd_err_kind, .rd_err_overflow,
		.wr_burst_done, .wr_err_valid, .wr_err_kind, .wr_err_overflow,
		.stats, .err_pulse
	);

endmodule

// ==== verification/axi4_mon_clkgen.sv ====
/*
 * Testbench clock and power-on reset source.
 */

`timescale 1ns/1ps

module axi4_mon_clkgen #(
	parameter int HALF_PERIOD  = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release just after an edge, same as the stimulus.
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

// ==== verification/tb_axi4_bus_monitor.sv ====
/*
 * AXI4 bus monitor testbench: seeded random traffic on all five channels,
 * a reference model of the burst rules and per-test counter checks.
 */

`timescale 1ns/1ps

module tb_axi4_bus_monitor;

	import axi4_mon_pkg::*;

	localparam int DEPTH      = 4;
	localparam int MAX_CYCLES = 4000;

	logic        clk;
	logic        por_n;
	logic        tb_rst_n;
	logic        rst_n;
	logic        ar_valid;
	logic        ar_ready;
	logic        aw_valid;
	logic        aw_ready;
	logic        r_valid;
	logic        r_ready;
	logic        w_valid;
	logic        w_ready;
	logic        b_valid;
	logic        b_ready;
	addr_chan_t  ar;
	addr_chan_t  aw;
	rbeat_t      r;
	wbeat_t      w;
	bresp_t      b;
	mon_stats_t  stats;
	logic        err_pulse;
	logic [95:0] rnd;
	logic        pulse_seen;
	integer      seed;
	int          cycles = 0;
	int          failures = 0;
	int          test_start_fail;
	int          tests_run = 0;
	int          tests_bad = 0;

	// reference model with the read side at index 0 and the write side at index 1.
	int exp_ar;
	int exp_aw;
	int exp_r;
	int exp_w;
	int exp_b;
	int exp_resp;
	int exp_last;
	int exp_orphan;
	int exp_ovf;
	int exp_bursts [2];
	int m_len [2][DEPTH];
	int m_head [2];
	int m_fill [2];
	int m_beats [2];

	// burst generator state.
	int g_end [2][DEPTH];
	bit g_lastf [2][DEPTH];
	int g_head [2];
	int g_fill [2];
	int g_beat [2];
	int g_issued [2];

	assign rst_n = por_n && tb_rst_n;

	axi4_mon_clkgen clkgen_inst (.clk(clk), .rst_n(por_n));

	axi4_bus_monitor #(.CNT_WIDTH(16), .BURST_DEPTH(DEPTH)) axi4_bus_monitor_inst (
		.clk, .rst_n,
		.ar_valid, .ar_ready, .ar, .aw_valid, .aw_ready, .aw,
		.r_valid, .r_ready, .r, .w_valid, .w_ready, .w,
		.b_valid, .b_ready, .b, .stats, .err_pulse
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("run stopped: cycle limit of %0d reached before the tests ended", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic rbit();
		logic [31:0] v;
		v = $random(seed);
		return v[0];
	endfunction

	function automatic int rnd_range(input int n);
		logic [31:0] v;
		v = $random(seed);
		return int'(v % 32'(n));
	endfunction

	function automatic logic [95:0] rnd_bits();
		return {$random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic idle_inputs();
		{ar_valid, ar_ready, aw_valid, aw_ready, r_valid, r_ready} = '0;
		{w_valid, w_ready, b_valid, b_ready} = '0;
		ar = '0;
		aw = '0;
		r = '0;
		w = '0;
		b = '0;
	endtask

	task automatic model_clear();
		{exp_ar, exp_aw, exp_r, exp_w, exp_b} = '0;
		{exp_resp, exp_last, exp_orphan, exp_ovf} = '0;
		for (int d = 0; d < 2; d++) begin
			exp_bursts[d] = 0;
			m_head[d] = 0;
			m_fill[d] = 0;
			m_beats[d] = 0;
		end
	endtask

	// beat against the current head first, then the new address.
	task automatic track(input int d, input bit addr_hs, input int len, input bit beat_hs,
			input bit last);
		bit popped;
		popped = 1'b0;
		if (beat_hs) begin
			if (m_fill[d] == 0) begin
				exp_orphan++;
			end else if (m_beats[d] == m_len[d][m_head[d]]) begin
				popped = 1'b1;
				if (last) exp_bursts[d]++;
				else exp_last++;
			end else if (last) begin
				popped = 1'b1;
				exp_last++;
			end else begin
				m_beats[d]++;
			end
		end
		if (popped) begin
			m_head[d] = (m_head[d] + 1) % DEPTH;
			m_fill[d]--;
			m_beats[d] = 0;
		end
		if (addr_hs && m_fill[d] < DEPTH) begin
			m_len[d][(m_head[d] + m_fill[d]) % DEPTH] = len;
			m_fill[d]++;
		end else if (addr_hs) begin
			exp_ovf++;
		end
	endtask

	task automatic model_cycle();
		if (ar_valid && ar_ready) exp_ar++;
		if (aw_valid && aw_ready) exp_aw++;
		if (r_valid && r_ready) exp_r++;
		if (w_valid && w_ready) exp_w++;
		if (b_valid && b_ready) exp_b++;
		if (r_valid && r_ready && r.resp != 2'b00) exp_resp++;
		if (b_valid && b_ready && b.resp != 2'b00) exp_resp++;
		track(0, ar_valid && ar_ready, int'(ar.len), r_valid && r_ready, r.last);
		track(1, aw_valid && aw_ready, int'(aw.len), w_valid && w_ready, w.last);
	endtask

	// inputs already set; the model sees them, then one clock passes.
	task automatic step();
		if (!tb_rst_n) model_clear();
		else model_cycle();
		@(posedge clk);
		#2;
		if (err_pulse) pulse_seen = 1'b1;
	endtask

	task automatic drive_random();
		logic [95:0] v;
		v = rnd_bits();
		ar_valid = rbit();
		ar_ready = rbit();
		ar = v[$bits(addr_chan_t)-1:0];
		v = rnd_bits();
		aw_valid = rbit();
		aw_ready = rbit();
		aw = v[$bits(addr_chan_t)-1:0];
		r_valid = rbit();
		r_ready = rbit();
		r = v[$bits(rbeat_t)+40:41];
		v = rnd_bits();
		w_valid = rbit();
		w_ready = rbit();
		w = v[$bits(wbeat_t)-1:0];
		b_valid = rbit();
		b_ready = rbit();
		b = v[$bits(bresp_t)+50:51];
	endtask

	// mode 0 legal, 1 last one beat early, 2 last missing.
	task automatic run_bursts(input int n, input bit corrupt);
		int mode;
		int len;
		int slot;
		bit av [2];
		bit ardy [2];
		bit bv [2];
		bit brdy [2];
		bit lastv [2];
		int lens [2];
		logic [95:0] v;
		for (int d = 0; d < 2; d++) begin
			{g_head[d], g_fill[d], g_beat[d], g_issued[d]} = '0;
		end
		while (g_issued[0] < n || g_issued[1] < n || g_fill[0] > 0 || g_fill[1] > 0) begin
			for (int d = 0; d < 2; d++) begin
				bv[d] = (g_fill[d] > 0) && rbit();
				brdy[d] = rnd_range(4) != 0;
				lastv[d] = 1'b0;
				if (g_fill[d] > 0 && g_beat[d] == g_end[d][g_head[d]]) begin
					lastv[d] = g_lastf[d][g_head[d]];
				end
				if (bv[d] && brdy[d] && g_beat[d] == g_end[d][g_head[d]]) begin
					g_head[d] = (g_head[d] + 1) % DEPTH;
					g_fill[d]--;
					g_beat[d] = 0;
				end else if (bv[d] && brdy[d]) begin
					g_beat[d]++;
				end
				av[d] = (g_issued[d] < n) && (g_fill[d] < 3) && rbit();
				ardy[d] = rnd_range(4) != 0;
				len = rnd_range(8);
				lens[d] = len;
				if (av[d] && ardy[d]) begin
					mode = corrupt ? rnd_range(3) : 0;
					if (len == 0 && mode == 1) mode = 0;
					slot = (g_head[d] + g_fill[d]) % DEPTH;
					g_end[d][slot] = (mode == 1) ? len - 1 : len;
					g_lastf[d][slot] = (mode != 2);
					g_fill[d]++;
					g_issued[d]++;
				end
			end
			v = rnd_bits();
			{ar_valid, ar_ready, r_valid, r_ready} = {av[0], ardy[0], bv[0], brdy[0]};
			{aw_valid, aw_ready, w_valid, w_ready} = {av[1], ardy[1], bv[1], brdy[1]};
			ar = v[$bits(addr_chan_t)-1:0];
			ar.len = 8'(lens[0]);
			aw = v[$bits(addr_chan_t)+10:11];
			aw.len = 8'(lens[1]);
			r = v[$bits(rbeat_t)-1:0];
			r.resp = 2'b00;
			r.last = lastv[0];
			w = v[$bits(wbeat_t)+50:51];
			w.last = lastv[1];
			step();
		end
	endtask

	task automatic note_failure(input string msg);
		$display("FAILURE at %0t: %s", $time, msg);
		failures++;
	endtask

	task automatic check_field(input string name, input int exp, input logic [15:0] act);
		if (act !== 16'(exp)) begin
			$display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
			failures++;
		end
	endtask

	task automatic compare_stats();
		int any;
		any = ((exp_resp + exp_last + exp_orphan + exp_ovf) > 0) ? 1 : 0;
		check_field("ar", exp_ar, stats.ar);
		check_field("aw", exp_aw, stats.aw);
		check_field("r_beats", exp_r, stats.r_beats);
		check_field("w_beats", exp_w, stats.w_beats);
		check_field("b_resp", exp_b, stats.b_resp);
		check_field("rd_bursts", exp_bursts[0], stats.rd_bursts);
		check_field("wr_bursts", exp_bursts[1], stats.wr_bursts);
		check_field("resp_err", exp_resp, stats.resp_err);
		check_field("last_err", exp_last, stats.last_err);
		check_field("orphan_err", exp_orphan, stats.orphan_err);
		check_field("overflow_err", exp_ovf, stats.overflow_err);
		check_field("any_err", any, 16'(stats.any_err));
	endtask

	task automatic settle_and_check();
		idle_inputs();
		repeat (4) step();
		compare_stats();
	endtask

	task automatic start_test();
		idle_inputs();
		tb_rst_n = 1'b0;
		step();
		step();
		tb_rst_n = 1'b1;
		pulse_seen = 1'b0;
		test_start_fail = failures;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (failures == test_start_fail) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d check(s) wrong", name, failures - test_start_fail);
			tests_bad++;
		end
	endtask

	initial begin
		seed = 44401;
		tb_rst_n = 1'b1;
		pulse_seen = 1'b0;
		idle_inputs();
		model_clear();
		wait (por_n);

		start_test();
		repeat (300) begin
			drive_random();
			step();
		end
		settle_and_check();
		finish_test("handshake counting");

		start_test();
		run_bursts(16, 1'b0);
		settle_and_check();
		check_field("rd_bursts", 16, stats.rd_bursts);
		check_field("wr_bursts", 16, stats.wr_bursts);
		check_field("resp_err", 0, stats.resp_err);
		check_field("last_err", 0, stats.last_err);
		check_field("orphan_err", 0, stats.orphan_err);
		check_field("overflow_err", 0, stats.overflow_err);
		check_field("any_err", 0, 16'(stats.any_err));
		if (pulse_seen) note_failure("err_pulse went high during legal bursts");
		finish_test("legal bursts");

		start_test();
		run_bursts(16, 1'b1);
		settle_and_check();
		if (exp_last == 0) note_failure("no LAST violation was generated");
		if (!pulse_seen) note_failure("err_pulse never went high on LAST violations");
		if (stats.any_err !== 1'b1) note_failure("any_err not set after LAST violations");
		finish_test("last violations");

		// beats with nothing queued, then more AW than the queue holds.
		start_test();
		repeat (4) begin
			rnd = rnd_bits();
			{r_valid, r_ready, w_valid, w_ready} = 4'b1111;
			r = rnd[$bits(rbeat_t)-1:0];
			w = rnd[$bits(wbeat_t)+50:51];
			step();
		end
		idle_inputs();
		repeat (6) begin
			rnd = rnd_bits();
			{aw_valid, aw_ready} = 2'b11;
			aw = rnd[$bits(addr_chan_t)-1:0];
			step();
		end
		settle_and_check();
		check_field("orphan_err", 8, stats.orphan_err);
		check_field("overflow_err", 2, stats.overflow_err);
		finish_test("orphan beats and overflow");

		start_test();
		repeat (100) begin
			rnd = rnd_bits();
			{r_valid, r_ready, b_valid, b_ready} = {rbit(), rbit(), rbit(), rbit()};
			r = rnd[$bits(rbeat_t)-1:0];
			b = rnd[$bits(bresp_t)+50:51];
			step();
		end
		settle_and_check();
		if (exp_resp == 0) note_failure("no error response was generated");
		finish_test("response errors");

		// reset lands while traffic is still running.
		start_test();
		repeat (40) begin
			drive_random();
			step();
		end
		tb_rst_n = 1'b0;
		repeat (3) begin
			drive_random();
			step();
		end
		tb_rst_n = 1'b1;
		settle_and_check();
		if (stats !== '0) note_failure("stats not cleared by a mid-run reset");
		run_bursts(1, 1'b0);
		settle_and_check();
		check_field("rd_bursts", 1, stats.rd_bursts);
		check_field("wr_bursts", 1, stats.wr_bursts);
		finish_test("reset clears state");

		$display("%0d tests run, %0d with errors, %0d failed checks", tests_run, tests_bad,
			failures);
		if (failures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== axi4_bus_monitor.f ====
hw/axi4_mon_pkg.sv
hw/axi4_handshake_decode.sv
hw/axi4_burst_tracker.sv
hw/axi4_mon_stats.sv
hw/axi4_bus_monitor.sv
verification/axi4_mon_clkgen.sv
verification/tb_axi4_bus_monitor.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing
TOP       := tb_axi4_bus_monitor
FLIST     := axi4_bus_monitor.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
